/* Makefile */
# Verilator flow for the vertex transform unit

VERILATOR ?= verilator
TOP       ?= vertexTransformTb
LOG       ?= sim.log
FLAGS     ?= --assert -Wno-fatal
FILELIST  ?= project.f
RTL_TOP   ?= vertexTransform

RTL_SRCS = \
	design/transformPkg.sv \
	design/commandDecoder.sv \
	design/vectorFifo.sv \
	design/matApply.sv \
	design/vertexTransform.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass or fail comes from the log, not the exit status
run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q ">>> PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --assert +incdir+design $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir $(LOG)

/* design/commandDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "transform_params.svh"

module commandDecoder (
	input  logic                clk,
	input  logic                rst,
	input  logic                inputEnable,
	input  transformPkg::cmdOpT cmdOp,
	input  transformPkg::fixT   inX,
	input  transformPkg::fixT   inY,
	input  transformPkg::fixT   inZ,
	input  logic                busy,
	output transformPkg::matT   matrix,
	output logic                wrEn,
	output transformPkg::fixT   wrX,
	output transformPkg::fixT   wrY,
	output transformPkg::fixT   wrZ
);
	import transformPkg::*;

	// Decoded strobes
	logic       rowLoad;
	logic [1:0] rowSel;
	logic       vecPush;

	////////////////////
	// Opcode decode
	////////////////////

	always_comb begin
		rowLoad = 1'b0;
		rowSel  = 2'd0;
		vecPush = 1'b0;
		if (inputEnable) begin
			case (cmdOp)
				CMD_ROW0: begin
					rowLoad = 1'b1;
					rowSel  = 2'd0;
				end
				CMD_ROW1: begin
					rowLoad = 1'b1;
					rowSel  = 2'd1;
				end
				CMD_ROW2: begin
					rowLoad = 1'b1;
					rowSel  = 2'd2;
				end
				CMD_VEC: vecPush = 1'b1;
				// NOP and undefined codes are ignored
				default: ;
			endcase
		end
	end

	////////////////////
	// Matrix registers
	////////////////////

	// Row takes x, y, z as its three columns
	always_ff @(posedge clk) begin
		if (rst) begin
			matrix <= '0;
		end else if (rowLoad) begin
			matrix[int'(rowSel) * 3 + 0] <= inX;
			matrix[int'(rowSel) * 3 + 1] <= inY;
			matrix[int'(rowSel) * 3 + 2] <= inZ;
		end
	end

	// Write strobe to the FIFO, one cycle after the command
	always_ff @(posedge clk) begin
		if (rst) begin
			wrEn <= 1'b0;
		end else begin
			wrEn <= vecPush;
		end
	end

	// Vector payload
	always_ff @(posedge clk) begin
		if (vecPush) begin
			wrX <= inX;
			wrY <= inY;
			wrZ <= inZ;
		end
	end

	// Matrix must not move under a running transform
	rowLoadIdle: assert property (@(posedge clk) disable iff (rst) rowLoad |-> !busy)
		else $error("matrix row loaded while the engine is busy");

endmodule

`default_nettype wire

/* design/matApply.sv */
`timescale 1ns/1ns
`default_nettype none

`include "transform_params.svh"

module matApply (
	input  logic              clk,
	input  logic              rst,
	input  transformPkg::matT matrix,
	input  logic              empty,
	input  transformPkg::fixT rdX,
	input  transformPkg::fixT rdY,
	input  transformPkg::fixT rdZ,
	output logic              rdEn,
	output transformPkg::fixT outVec_x,
	output transformPkg::fixT outVec_y,
	output transformPkg::fixT outVec_z,
	output logic              outputEnable,
	output logic              busy
);
	import transformPkg::*;

	// Clamp limits in accumulator width
	localparam accT fixMax = accT'((2 ** (`TF_FIX_W - 1)) - 1);
	localparam accT fixMin = -fixMax - accT'(1);

	applyStateT state;

	// Latched operand vector
	fixT vecX;
	fixT vecY;
	fixT vecZ;

	// Element position in the matrix walk
	logic [1:0] row;
	logic [1:0] col;

	accT acc;

	// Single multiplier datapath
	fixT                           coef;
	fixT                           operand;
	logic signed [2*`TF_FIX_W-1:0] prod;
	accT                           sum;
	fixT                           rowResult;

	// Floor shift back to the fixed point scale, then clamp
	function automatic fixT saturate(input accT value);
		accT shifted;
		shifted = value >>> `TF_FRAC_BITS;
		if (shifted > fixMax) begin
			return fixT'(fixMax);
		end else if (shifted < fixMin) begin
			return fixT'(fixMin);
		end
		return fixT'(shifted);
	endfunction

	////////////////////
	// MAC datapath
	////////////////////

	always_comb begin
		coef = matrix[int'(row) * 3 + int'(col)];
		case (col)
			2'd0:    operand = vecX;
			2'd1:    operand = vecY;
			default: operand = vecZ;
		endcase
		prod = coef * operand;
		// First column starts a fresh dot product
		sum = (col == 2'd0) ? accT'(prod) : acc + accT'(prod);
		rowResult = saturate(sum);
	end

	// Pop in idle whenever a vector waits
	assign rdEn         = (state == ST_IDLE) && !empty;
	assign outputEnable = (state == ST_OUT);
	assign busy         = !empty || (state != ST_IDLE);

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			row   <= 2'd0;
			col   <= 2'd0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (!empty) begin
						state <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					row   <= 2'd0;
					col   <= 2'd0;
					state <= ST_MAC;
				end
				ST_MAC: begin
					if (col == 2'd2) begin
						col <= 2'd0;
						row <= row + 2'd1;
						// Ninth product done
						if (row == 2'd2) begin
							state <= ST_OUT;
						end
					end else begin
						col <= col + 2'd1;
					end
				end
				ST_OUT: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Operands, accumulator and result rows
	always_ff @(posedge clk) begin
		if (rdEn) begin
			vecX <= rdX;
			vecY <= rdY;
			vecZ <= rdZ;
		end
		if (state == ST_MAC) begin
			acc <= sum;
			if (col == 2'd2) begin
				case (row)
					2'd0:    outVec_x <= rowResult;
					2'd1:    outVec_y <= rowResult;
					default: outVec_z <= rowResult;
				endcase
			end
		end
	end

	// Result strobe is a single cycle
	oePulse: assert property (@(posedge clk) disable iff (rst)
		outputEnable |=> !outputEnable)
		else $error("outputEnable held longer than one cycle");

	// Fixed engine latency from pop to result
	popToResult: assert property (@(posedge clk) disable iff (rst)
		rdEn |-> ##11 outputEnable)
		else $error("result strobe not 11 cycles after pop");

endmodule

`default_nettype wire

/* design/transformPkg.sv */
`default_nettype none

`include "transform_params.svh"

package transformPkg;

	////////////////////
	// Data types
	////////////////////

	// One signed fixed point number
	typedef logic signed [`TF_FIX_W-1:0] fixT;

	// Row major 3x3 matrix, element r*3+c
	typedef fixT [8:0] matT;

	// Dot product accumulator
	// Two guard bits over the raw product for the three term sum
	typedef logic signed [2*`TF_FIX_W+1:0] accT;

	////////////////////
	// Encodings
	////////////////////

	// Command port opcodes
	typedef enum logic [2:0] {
		CMD_NOP  = 3'd0,
		CMD_ROW0 = 3'd1,
		CMD_ROW1 = 3'd2,
		CMD_ROW2 = 3'd3,
		CMD_VEC  = 3'd4
	} cmdOpT;

	// Engine FSM states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_MAC,
		ST_OUT
	} applyStateT;

endpackage

`default_nettype wire

/* design/transform_params.svh */
`ifndef TRANSFORM_PARAMS_SVH
`define TRANSFORM_PARAMS_SVH

// Fixed point format, sign bit plus integer and fraction bits
`define TF_INT_BITS 4
`define TF_FRAC_BITS 8

// Full word width, 13 bits with the defaults
`define TF_FIX_W (1 + `TF_INT_BITS + `TF_FRAC_BITS)

// Vector FIFO depth
// Power of two so the pointers wrap on their own
`define TF_FIFO_DEPTH 8

`endif

/* design/vectorFifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "transform_params.svh"

module vectorFifo #(
	parameter int DEPTH = `TF_FIFO_DEPTH
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              wrEn,
	input  transformPkg::fixT wrX,
	input  transformPkg::fixT wrY,
	input  transformPkg::fixT wrZ,
	input  logic              rdEn,
	output transformPkg::fixT rdX,
	output transformPkg::fixT rdY,
	output transformPkg::fixT rdZ,
	output logic              empty,
	output logic              overflow
);
	import transformPkg::*;

	// DEPTH is a power of two, at least 2
	localparam int addrW = $clog2(DEPTH);

	// Slot holds x in [0], y in [1], z in [2]
	fixT [2:0] mem [DEPTH];

	logic [addrW-1:0] wrPtr;
	logic [addrW-1:0] rdPtr;
	logic [addrW:0]   count;

	logic stored;
	logic full;
	logic doWrite;

	////////////////////
	// Flags
	////////////////////

	assign stored = (count != '0);
	assign full   = (count == (addrW + 1)'(DEPTH));

	// Empty looks through a write landing this cycle
	// so an idle engine can take the vector straight away
	assign empty = !stored && !wrEn;

	// Write goes in unless full, a read in the same cycle frees a slot
	assign doWrite = wrEn && (!full || rdEn);

	// Head of queue, or the incoming vector when nothing is stored
	assign rdX = stored ? mem[rdPtr][0] : wrX;
	assign rdY = stored ? mem[rdPtr][1] : wrY;
	assign rdZ = stored ? mem[rdPtr][2] : wrZ;

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge clk) begin
		if (doWrite) begin
			mem[wrPtr] <= {wrZ, wrY, wrX};
		end
	end

	// Pointers and occupancy
	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (rdEn) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doWrite, rdEn})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// Sticky drop flag, only rst clears it
	always_ff @(posedge clk) begin
		if (rst) begin
			overflow <= 1'b0;
		end else if (wrEn && !doWrite) begin
			overflow <= 1'b1;
		end
	end

	// Engine pops only with data present
	noReadEmpty: assert property (@(posedge clk) disable iff (rst) rdEn |-> !empty)
		else $error("FIFO read while empty");

	// Occupancy bound
	countBound: assert property (@(posedge clk) disable iff (rst) count <= DEPTH)
		else $error("FIFO count above DEPTH");

endmodule

`default_nettype wire

/* design/vertexTransform.sv */
`timescale 1ns/1ns
`default_nettype none

`include "transform_params.svh"

module vertexTransform (
	input  logic                clk,
	input  logic                rst,
	input  logic                inputEnable,
	input  transformPkg::cmdOpT cmdOp,
	input  transformPkg::fixT   inX,
	input  transformPkg::fixT   inY,
	input  transformPkg::fixT   inZ,
	output transformPkg::fixT   outVec_x,
	output transformPkg::fixT   outVec_y,
	output transformPkg::fixT   outVec_z,
	output logic                outputEnable,
	output logic                busy,
	output logic                overflow
);

	////////////////////
	// Internal nets
	////////////////////

	// Decoder to engine
	transformPkg::matT matrix;

	// Decoder to FIFO
	logic              wrEn;
	transformPkg::fixT wrX;
	transformPkg::fixT wrY;
	transformPkg::fixT wrZ;

	// FIFO to engine
	logic              empty;
	logic              rdEn;
	transformPkg::fixT rdX;
	transformPkg::fixT rdY;
	transformPkg::fixT rdZ;

	// Command side, matrix and vector pushes
	commandDecoder commandDecoder_inst (
		.clk         (clk),
		.rst         (rst),
		.inputEnable (inputEnable),
		.cmdOp       (cmdOp),
		.inX         (inX),
		.inY         (inY),
		.inZ         (inZ),
		.busy        (busy),
		.matrix      (matrix),
		.wrEn        (wrEn),
		.wrX         (wrX),
		.wrY         (wrY),
		.wrZ         (wrZ)
	);

	// Vector queue
	vectorFifo #(
		.DEPTH (`TF_FIFO_DEPTH)
	) vectorFifo_inst (
		.clk      (clk),
		.rst      (rst),
		.wrEn     (wrEn),
		.wrX      (wrX),
		.wrY      (wrY),
		.wrZ      (wrZ),
		.rdEn     (rdEn),
		.rdX      (rdX),
		.rdY      (rdY),
		.rdZ      (rdZ),
		.empty    (empty),
		.overflow (overflow)
	);

	// Transform engine
	matApply matApply_inst (
		.clk          (clk),
		.rst          (rst),
		.matrix       (matrix),
		.empty        (empty),
		.rdX          (rdX),
		.rdY          (rdY),
		.rdZ          (rdZ),
		.rdEn         (rdEn),
		.outVec_x     (outVec_x),
		.outVec_y     (outVec_y),
		.outVec_z     (outVec_z),
		.outputEnable (outputEnable),
		.busy         (busy)
	);

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/transformPkg.sv
design/commandDecoder.sv
design/vectorFifo.sv
design/matApply.sv
design/vertexTransform.sv
testbench/vertexTransformTb.sv

/* testbench/vertexTransformTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "transform_params.svh"

module vertexTransformTb;
	import transformPkg::*;

	// Run limit, about 220 vectors at up to 19 cycles each plus loads and margin
	localparam int maxCycles = 6000;

	// Clamp limits of one fixed point word
	localparam longint fixHi = (longint'(1) <<< (`TF_FIX_W - 1)) - 1;
	localparam longint fixLo = -fixHi - 1;

	// DUT ports
	logic  clk;
	logic  rst;
	logic  inputEnable;
	cmdOpT cmdOp;
	fixT   inX;
	fixT   inY;
	fixT   inZ;
	fixT   outVec_x;
	fixT   outVec_y;
	fixT   outVec_z;
	logic  outputEnable;
	logic  busy;
	logic  overflow;

	int seed = 63;
	int cycleCount = 0;
	int strobeCycle = 0;
	int errors = 0;
	int checks = 0;

	// Reference model state
	fixT modelMat [9];
	fixT expX [$];
	fixT expY [$];
	fixT expZ [$];

	// Results seen on the output strobe
	fixT gotX [$];
	fixT gotY [$];
	fixT gotZ [$];
	int  gotCycle [$];

	vertexTransform vertexTransform_inst (
		.clk          (clk),
		.rst          (rst),
		.inputEnable  (inputEnable),
		.cmdOp        (cmdOp),
		.inX          (inX),
		.inY          (inY),
		.inZ          (inZ),
		.outVec_x     (outVec_x),
		.outVec_y     (outVec_y),
		.outVec_z     (outVec_z),
		.outputEnable (outputEnable),
		.busy         (busy),
		.overflow     (overflow)
	);

	////////////////////
	// Clock, watchdog, monitor
	////////////////////

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= maxCycles) begin
			$display("Timeout: run stopped after %0d cycles waiting for results", maxCycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// Outputs are stable mid cycle
	always @(negedge clk) begin
		if (!rst && outputEnable) begin
			gotX.push_back(outVec_x);
			gotY.push_back(outVec_y);
			gotZ.push_back(outVec_z);
			gotCycle.push_back(cycleCount);
		end
	end

	////////////////////
	// Model
	////////////////////

	// Full range when span is 0
	function automatic fixT randFix(input int span);
		int raw;
		raw = $random(seed);
		if (span > 0) begin
			raw = raw % span;
		end
		return fixT'(raw);
	endfunction

	// Exact dot product, floor shift, clamp
	function automatic fixT expectedRow(input int r, input fixT x, input fixT y, input fixT z);
		longint dot;
		longint scaled;
		dot = longint'(modelMat[r * 3]) * longint'(x);
		dot = dot + longint'(modelMat[r * 3 + 1]) * longint'(y);
		dot = dot + longint'(modelMat[r * 3 + 2]) * longint'(z);
		scaled = dot >>> `TF_FRAC_BITS;
		if (scaled > fixHi) begin
			scaled = fixHi;
		end else if (scaled < fixLo) begin
			scaled = fixLo;
		end
		return fixT'(scaled);
	endfunction

	////////////////////
	// Compare tasks
	////////////////////

	task automatic checkVec(input string name, input fixT ex, ey, ez, input fixT ax, ay, az);
		checks++;
		if (ex !== ax || ey !== ay || ez !== az) begin
			errors++;
			$display("Error %s: expected (%0d, %0d, %0d), actual (%0d, %0d, %0d)",
				name, ex, ey, ez, ax, ay, az);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Error %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	// Latencies and result counts
	task automatic checkCount(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("Error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	task automatic issueCmd(input cmdOpT op, input fixT x, input fixT y, input fixT z);
		@(posedge clk);
		#2;
		inputEnable = 1'b1;
		cmdOp       = op;
		inX         = x;
		inY         = y;
		inZ         = z;
		strobeCycle = cycleCount;
	endtask

	task automatic holdIdle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
			inputEnable = 1'b0;
		end
	endtask

	// Operands move while the strobe stays low
	task automatic driveQuiet(input cmdOpT op, input fixT x, input fixT y, input fixT z);
		@(posedge clk);
		#2;
		inputEnable = 1'b0;
		cmdOp       = op;
		inX         = x;
		inY         = y;
		inZ         = z;
	endtask

	task automatic loadRow(input int r, input fixT a, input fixT b, input fixT c);
		cmdOpT op;
		case (r)
			0:       op = CMD_ROW0;
			1:       op = CMD_ROW1;
			default: op = CMD_ROW2;
		endcase
		issueCmd(op, a, b, c);
		modelMat[r * 3]     = a;
		modelMat[r * 3 + 1] = b;
		modelMat[r * 3 + 2] = c;
	endtask

	// Coefficients within about +-2.3
	task automatic loadRandomMatrix();
		fixT a;
		fixT b;
		fixT c;
		for (int r = 0; r < 3; r++) begin
			a = randFix(600);
			b = randFix(600);
			c = randFix(600);
			loadRow(r, a, b, c);
		end
	endtask

	task automatic pushVector(input fixT x, input fixT y, input fixT z);
		issueCmd(CMD_VEC, x, y, z);
		expX.push_back(expectedRow(0, x, y, z));
		expY.push_back(expectedRow(1, x, y, z));
		expZ.push_back(expectedRow(2, x, y, z));
	endtask

	// Next strobe comes gap cycles later
	task automatic pushRandom(input int gap);
		fixT x;
		fixT y;
		fixT z;
		x = randFix(0);
		y = randFix(0);
		z = randFix(0);
		pushVector(x, y, z);
		holdIdle(gap - 1);
	endtask

	task automatic waitIdle();
		holdIdle(1);
		@(negedge clk);
		while (busy) begin
			@(negedge clk);
		end
	endtask

	task automatic clearQueues();
		expX.delete();
		expY.delete();
		expZ.delete();
		gotX.delete();
		gotY.delete();
		gotZ.delete();
		gotCycle.delete();
	endtask

	// In order match of every result, then flush
	task automatic compareQueues(input string name);
		checkCount({name, " result count"}, expX.size(), gotX.size());
		for (int i = 0; i < expX.size() && i < gotX.size(); i++) begin
			checkVec(name, expX[i], expY[i], expZ[i], gotX[i], gotY[i], gotZ[i]);
		end
		clearQueues();
	endtask

	task automatic resetDut();
		rst         = 1'b1;
		inputEnable = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int i = 0; i < 9; i++) begin
			modelMat[i] = '0;
		end
		clearQueues();
	endtask

	task automatic testDone(input int num, input string name, input int e0, input int c0);
		$display("Test %0d %s finished: %0d checks, %0d errors",
			num, name, checks - c0, errors - e0);
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int  e0;
		int  c0;
		int  k;
		int  j;
		fixT vx;
		fixT vy;
		fixT vz;
		fixT r0x;
		fixT r0y;
		fixT r0z;
		fixT a;
		fixT b;
		fixT c;

		rst         = 1'b1;
		inputEnable = 1'b0;
		cmdOp       = CMD_NOP;
		inX         = '0;
		inY         = '0;
		inZ         = '0;
		resetDut();

		// Identity, fixed latency, busy drops
		e0 = errors;
		c0 = checks;
		loadRow(0, 256, 0, 0);
		loadRow(1, 0, 256, 0);
		loadRow(2, 0, 0, 256);
		pushVector(404, 33, 1);
		holdIdle(1);
		while (gotX.size() < 1) @(negedge clk);
		@(negedge clk);
		checkFlag("identity busy", 1'b0, busy);
		checkVec("identity passthrough", 404, 33, 1, gotX[0], gotY[0], gotZ[0]);
		checkCount("identity latency", 12, gotCycle[0] - strobeCycle);
		waitIdle();
		compareQueues("identity");
		testDone(1, "identity", e0, c0);

		// Five matrices, 40 spaced vectors each
		e0 = errors;
		c0 = checks;
		repeat (5) begin
			waitIdle();
			loadRandomMatrix();
			repeat (40) pushRandom(12 + ($random(seed) & 7));
		end
		waitIdle();
		compareQueues("random stream");
		checkFlag("random stream overflow", 1'b0, overflow);
		testDone(2, "random stream", e0, c0);

		// Clamp at both ends, floor on negative sums
		e0 = errors;
		c0 = checks;
		waitIdle();
		loadRow(0, 4095, 4095, 4095);
		loadRow(1, -4096, 4095, -4096);
		loadRow(2, 1, 3, -2);
		pushVector(4095, 4095, 4095);
		holdIdle(11);
		pushVector(-4096, -4096, -4096);
		holdIdle(11);
		pushVector(4095, -4096, 4095);
		holdIdle(11);
		pushVector(-1, -1, 0);
		holdIdle(11);
		pushVector(-300, 50, 7);
		holdIdle(11);
		pushVector(0, -4096, 1);
		waitIdle();
		checkVec("saturation clamp", 4095, -4096, 31, gotX[0], gotY[0], gotZ[0]);
		checkVec("saturation floor", -32, 0, -1, gotX[3], gotY[3], gotZ[3]);
		compareQueues("saturation");
		testDone(3, "saturation", e0, c0);

		// Back to back burst into the FIFO
		e0 = errors;
		c0 = checks;
		waitIdle();
		loadRandomMatrix();
		repeat (14) pushRandom(1);
		waitIdle();
		k = gotX.size();
		checks++;
		if (k < `TF_FIFO_DEPTH || k >= 14) begin
			errors++;
			$display("Overflow burst gave %0d results, not between %0d and 13",
				k, `TF_FIFO_DEPTH);
		end
		for (int i = 0; i < `TF_FIFO_DEPTH && i < k; i++) begin
			checkVec("overflow head", expX[i], expY[i], expZ[i], gotX[i], gotY[i], gotZ[i]);
		end
		// Later results are survivors of the burst, still in push order
		j = `TF_FIFO_DEPTH;
		for (int i = `TF_FIFO_DEPTH; i < k; i++) begin
			while (j < 14 && !(expX[j] == gotX[i] && expY[j] == gotY[i] && expZ[j] == gotZ[i]))
				j++;
			checks++;
			if (j >= 14) begin
				errors++;
				$display("Overflow result %0d matches no later push of the burst", i);
			end else begin
				j++;
			end
		end
		checkFlag("overflow sticky", 1'b1, overflow);
		checkFlag("overflow drained busy", 1'b0, busy);
		clearQueues();
		testDone(4, "overflow", e0, c0);

		// Ignored commands and single row reload
		e0 = errors;
		c0 = checks;
		waitIdle();
		holdIdle(1);
		resetDut();
		checkFlag("decode overflow cleared", 1'b0, overflow);
		loadRandomMatrix();
		vx = randFix(0);
		vy = randFix(0);
		vz = randFix(0);
		pushVector(vx, vy, vz);
		waitIdle();
		// Model result of the base vector
		r0x = expX[0];
		r0y = expY[0];
		r0z = expZ[0];
		compareQueues("decode base");
		issueCmd(CMD_NOP, randFix(0), randFix(0), randFix(0));
		issueCmd(cmdOpT'(3'd7), randFix(0), randFix(0), randFix(0));
		issueCmd(CMD_NOP, randFix(0), randFix(0), randFix(0));
		driveQuiet(CMD_ROW1, randFix(0), randFix(0), randFix(0));
		driveQuiet(CMD_VEC, randFix(0), randFix(0), randFix(0));
		waitIdle();
		checkCount("decode ignored outputs", 0, gotX.size());
		pushVector(vx, vy, vz);
		waitIdle();
		checkVec("decode matrix kept", r0x, r0y, r0z, gotX[0], gotY[0], gotZ[0]);
		compareQueues("decode repeat");
		a = randFix(600);
		b = randFix(600);
		c = randFix(600);
		loadRow(1, a, b, c);
		pushVector(vx, vy, vz);
		waitIdle();
		checkVec("decode row reload", r0x, expY[0], r0z, gotX[0], gotY[0], gotZ[0]);
		compareQueues("decode reload");
		testDone(5, "command decode", e0, c0);

		$display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
